//--- common/mshr_pkg.sv
package mshr_pkg;

    // ========================================
    // sizes
    // ========================================
    localparam int MSHR_ENTRY_NUM = 4;
    localparam int ENTRY_ID_W     = $clog2(MSHR_ENTRY_NUM);
    localparam int TAG_W          = 10;
    localparam int INDEX_W        = 6;
    localparam int OFFSET_W       = 4;
    localparam int WAY_W          = 2;
    localparam int TXN_ID_W       = 4;
    localparam int WDB_ID_W       = 3;
    localparam int DEST_RAM_W     = 5;    // top tag bits, hash id plus ram id

    // ========================================
    // data-RAM opcodes
    // ========================================
    localparam int              OPC_W     = 2;
    localparam logic [OPC_W-1:0] OPC_WRITE = 2'd0;
    localparam logic [OPC_W-1:0] OPC_READ  = 2'd1;

    // ========================================
    // request structs
    // ========================================
    // request as it arrives from the tag pipeline
    typedef struct packed {
        logic [TXN_ID_W-1:0]   txn_id;
        logic                  is_write;
        logic                  hit;
        logic [TAG_W-1:0]      tag;
        logic [INDEX_W-1:0]    index;
        logic [OFFSET_W-1:0]   offset;
        logic [WAY_W-1:0]      way;
        logic [WDB_ID_W-1:0]   wdb_id;     // write data buffer slot
    } cache_req_t;

    // broadcast from the allocator to all entries
    typedef struct packed {
        cache_req_t                req;
        logic [MSHR_ENTRY_NUM-1:0] hzd_bitmap;  // older entries on the same set
    } mshr_alloc_t;

    // line request to the next level
    typedef struct packed {
        logic [ENTRY_ID_W-1:0] entry_id;
        logic [TXN_ID_W-1:0]   txn_id;
        logic [TAG_W-1:0]      tag;
        logic [INDEX_W-1:0]    index;
        logic [OFFSET_W-1:0]   offset;
    } ds_req_t;

    // read or write of the data RAM
    typedef struct packed {
        logic [ENTRY_ID_W-1:0] entry_id;
        logic [TXN_ID_W-1:0]   txn_id;
        logic [OPC_W-1:0]      opcode;
        logic [WAY_W-1:0]      way;
        logic [INDEX_W-1:0]    index;
        logic [OFFSET_W-1:0]   offset;
        logic [DEST_RAM_W-1:0] dest_ram_id;
        logic [WDB_ID_W-1:0]   wdb_id;      // zero on reads
    } ram_req_t;

endpackage

//--- hdl/mshr_alloc.sv
`timescale 1ns/1ps

module mshr_alloc
    import mshr_pkg::*;
(
    input  logic                           req_vld,
    input  cache_req_t                     req,
    output logic                           req_rdy,
    input  logic [MSHR_ENTRY_NUM-1:0]      entry_active,
    input  cache_req_t [MSHR_ENTRY_NUM-1:0] entry_req,
    input  logic [MSHR_ENTRY_NUM-1:0]      release_vec,
    output logic [MSHR_ENTRY_NUM-1:0]      update_vec,
    output mshr_alloc_t                    alloc
);

    logic [ENTRY_ID_W-1:0] free_idx;
    logic                  accept;

    // ========================================
    // free entry pick
    // ========================================
    // lowest numbered inactive entry wins
    always_comb begin
        free_idx = '0;
        for (int i = MSHR_ENTRY_NUM - 1; i >= 0; i--) begin
            if (!entry_active[i]) begin
                free_idx = ENTRY_ID_W'(i);
            end
        end
    end

    assign req_rdy    = ~&entry_active;     // room while any entry is idle
    assign accept     = req_vld && req_rdy;
    assign update_vec = MSHR_ENTRY_NUM'(accept) << free_idx;

    // ========================================
    // same-set hazard bitmap
    // ========================================
    // an entry releasing this cycle is already gone for the new request,
    // otherwise its bit would never be cleared
    always_comb begin
        alloc.req = req;
        for (int i = 0; i < MSHR_ENTRY_NUM; i++) begin
            alloc.hzd_bitmap[i] = entry_active[i]
                                && !release_vec[i]
                                && (entry_req[i].index == req.index);
        end
    end

endmodule

//--- mshr_entry/mshr_entry.sv
`timescale 1ns/1ps

module mshr_entry
    import mshr_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      update_en,
    input  mshr_alloc_t               alloc,
    input  logic [MSHR_ENTRY_NUM-1:0] release_vec,
    input  logic                      ds_grant,
    input  logic                      ram_grant,
    input  logic                      lf_done,
    input  logic                      acc_done,
    output logic                      active,
    output cache_req_t                entry_req,
    output logic                      ds_want,
    output logic                      ram_want,
    output logic                      release_en
);

    logic [MSHR_ENTRY_NUM-1:0] hzd_bitmap;
    logic                      hazard_free;
    logic                      linefill_sent;
    logic                      linefill_done;
    logic                      access_sent;
    logic                      access_done;

    assign release_en = acc_done;   // ram access finished, entry is done

    // ========================================
    // stored request
    // ========================================
    always_ff @(posedge clk) begin
        if (update_en) begin
            entry_req <= alloc.req;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
        end else if (update_en) begin
            active <= 1'b1;
        end else if (release_en) begin
            active <= 1'b0;
        end
    end

    // ========================================
    // hazard wait
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hzd_bitmap <= '0;
        end else if (update_en) begin
            hzd_bitmap <= alloc.hzd_bitmap;
        end else begin
            hzd_bitmap <= hzd_bitmap & ~release_vec;    // older entries drop out
        end
    end

    // one edge behind the bitmap
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hazard_free <= 1'b0;
        end else if (update_en) begin
            hazard_free <= 1'b0;
        end else begin
            hazard_free <= active && !release_en && (hzd_bitmap == '0);
        end
    end

    // ========================================
    // progress flags
    // ========================================
    // a hit needs no linefill, so both linefill flags start as done
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            linefill_sent <= 1'b0;
            linefill_done <= 1'b0;
            access_sent   <= 1'b0;
            access_done   <= 1'b0;
        end else if (update_en) begin
            linefill_sent <= alloc.req.hit;
            linefill_done <= alloc.req.hit;
            access_sent   <= 1'b0;
            access_done   <= 1'b0;
        end else begin
            if (ds_grant) linefill_sent <= 1'b1;
            if (lf_done) linefill_done <= 1'b1;     // line written into ram
            if (ram_grant) access_sent <= 1'b1;
            if (acc_done) access_done <= 1'b1;
        end
    end

    assign ds_want  = active && hazard_free && !linefill_sent;
    assign ram_want = active && hazard_free && linefill_done && !access_sent;

    // ========================================
    // checks
    // ========================================
    lf_done_outstanding: assert property (
        @(posedge clk) disable iff (!rst_n)
        lf_done |-> active && linefill_sent && !linefill_done
    );

    acc_done_outstanding: assert property (
        @(posedge clk) disable iff (!rst_n)
        acc_done |-> active && access_sent && !access_done
    );

    update_only_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        update_en |-> !active
    );

endmodule

//--- hdl/mshr_issue.sv
`timescale 1ns/1ps

module mshr_issue
    import mshr_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [MSHR_ENTRY_NUM-1:0]       ds_want,
    input  logic [MSHR_ENTRY_NUM-1:0]       ram_want,
    input  cache_req_t [MSHR_ENTRY_NUM-1:0] entry_req,
    input  logic                            ds_rdy,
    input  logic                            ram_rdy,
    input  logic                            linefill_done,
    input  logic [ENTRY_ID_W-1:0]           linefill_done_id,
    input  logic                            ram_done,
    input  logic [ENTRY_ID_W-1:0]           ram_done_id,
    output logic [MSHR_ENTRY_NUM-1:0]       ds_grant,
    output logic [MSHR_ENTRY_NUM-1:0]       ram_grant,
    output logic                            ds_req_vld,
    output ds_req_t                         ds_req,
    output logic                            ram_req_vld,
    output ram_req_t                        ram_req,
    output logic [MSHR_ENTRY_NUM-1:0]       lf_done_vec,
    output logic [MSHR_ENTRY_NUM-1:0]       acc_done_vec,
    output logic [MSHR_ENTRY_NUM-1:0]       release_vec
);

    logic [ENTRY_ID_W-1:0] ds_ptr;
    logic [ENTRY_ID_W-1:0] ram_ptr;
    logic [ENTRY_ID_W-1:0] ds_sel;
    logic [ENTRY_ID_W-1:0] ram_sel;
    logic                  ds_fire;
    logic                  ram_fire;
    cache_req_t            ds_src;
    cache_req_t            ram_src;

    // first requester at or after ptr
    function automatic logic [ENTRY_ID_W-1:0] rr_pick(
        input logic [MSHR_ENTRY_NUM-1:0] want,
        input logic [ENTRY_ID_W-1:0]     ptr
    );
        logic [ENTRY_ID_W-1:0] idx;
        logic [ENTRY_ID_W-1:0] pick;
        pick = ptr;
        for (int o = MSHR_ENTRY_NUM - 1; o >= 0; o--) begin
            idx = ptr + ENTRY_ID_W'(o);
            if (want[idx]) pick = idx;
        end
        return pick;
    endfunction

    // ========================================
    // round-robin arbitration
    // ========================================
    assign ds_sel      = rr_pick(ds_want, ds_ptr);
    assign ram_sel     = rr_pick(ram_want, ram_ptr);
    assign ds_req_vld  = |ds_want;
    assign ram_req_vld = |ram_want;
    assign ds_fire     = ds_req_vld && ds_rdy;
    assign ram_fire    = ram_req_vld && ram_rdy;
    assign ds_grant    = MSHR_ENTRY_NUM'(ds_fire) << ds_sel;
    assign ram_grant   = MSHR_ENTRY_NUM'(ram_fire) << ram_sel;

    // a stalled winner keeps top priority until its handshake
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ds_ptr  <= '0;
            ram_ptr <= '0;
        end else begin
            if (ds_fire) begin
                ds_ptr <= ds_sel + ENTRY_ID_W'(1);
            end else if (ds_req_vld) begin
                ds_ptr <= ds_sel;
            end
            if (ram_fire) begin
                ram_ptr <= ram_sel + ENTRY_ID_W'(1);
            end else if (ram_req_vld) begin
                ram_ptr <= ram_sel;
            end
        end
    end

    // ========================================
    // payload build
    // ========================================
    always_comb begin
        ds_src          = entry_req[ds_sel];
        ds_req.entry_id = ds_sel;
        ds_req.txn_id   = ds_src.txn_id;
        ds_req.tag      = ds_src.tag;
        ds_req.index    = ds_src.index;
        ds_req.offset   = ds_src.offset;
    end

    always_comb begin
        ram_src             = entry_req[ram_sel];
        ram_req.entry_id    = ram_sel;
        ram_req.txn_id      = ram_src.txn_id;
        ram_req.opcode      = ram_src.is_write ? OPC_WRITE : OPC_READ;
        ram_req.way         = ram_src.way;
        ram_req.index       = ram_src.index;
        ram_req.offset      = ram_src.offset;
        ram_req.dest_ram_id = ram_src.tag[TAG_W-1 -: DEST_RAM_W];
        ram_req.wdb_id      = ram_src.is_write ? ram_src.wdb_id : '0;  // reads carry no slot
    end

    // completion ids to one-hot
    assign lf_done_vec  = MSHR_ENTRY_NUM'(linefill_done) << linefill_done_id;
    assign acc_done_vec = MSHR_ENTRY_NUM'(ram_done) << ram_done_id;
    assign release_vec  = acc_done_vec;

    // ========================================
    // checks
    // ========================================
    ds_hold_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        ds_req_vld && !ds_rdy |=> ds_req_vld && $stable(ds_req)
    );

    ram_hold_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        ram_req_vld && !ram_rdy |=> ram_req_vld && $stable(ram_req)
    );

endmodule

//--- hdl/mshr_top.sv
`timescale 1ns/1ps

module mshr_top
    import mshr_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_vld,
    input  cache_req_t            req,
    output logic                  req_rdy,
    output logic                  ds_req_vld,
    output ds_req_t               ds_req,
    input  logic                  ds_rdy,
    output logic                  ram_req_vld,
    output ram_req_t              ram_req,
    input  logic                  ram_rdy,
    input  logic                  linefill_done,
    input  logic [ENTRY_ID_W-1:0] linefill_done_id,
    input  logic                  ram_done,
    input  logic [ENTRY_ID_W-1:0] ram_done_id
);

    logic [MSHR_ENTRY_NUM-1:0]       update_vec;
    logic [MSHR_ENTRY_NUM-1:0]       entry_active;
    logic [MSHR_ENTRY_NUM-1:0]       entry_release;
    logic [MSHR_ENTRY_NUM-1:0]       ds_want;
    logic [MSHR_ENTRY_NUM-1:0]       ram_want;
    logic [MSHR_ENTRY_NUM-1:0]       ds_grant;
    logic [MSHR_ENTRY_NUM-1:0]       ram_grant;
    logic [MSHR_ENTRY_NUM-1:0]       lf_done_vec;
    logic [MSHR_ENTRY_NUM-1:0]       acc_done_vec;
    logic [MSHR_ENTRY_NUM-1:0]       release_vec;
    cache_req_t [MSHR_ENTRY_NUM-1:0] entry_req;
    mshr_alloc_t                     alloc;

    mshr_alloc mshr_alloc_inst (
        .req_vld      (req_vld),
        .req          (req),
        .req_rdy      (req_rdy),
        .entry_active (entry_active),
        .entry_req    (entry_req),
        .release_vec  (entry_release),     // entries finishing this cycle
        .update_vec   (update_vec),
        .alloc        (alloc)
    );

    for (genvar i = 0; i < MSHR_ENTRY_NUM; i++) begin : g_entry
        mshr_entry mshr_entry_inst (
            .clk         (clk),
            .rst_n       (rst_n),
            .update_en   (update_vec[i]),
            .alloc       (alloc),
            .release_vec (release_vec),
            .ds_grant    (ds_grant[i]),
            .ram_grant   (ram_grant[i]),
            .lf_done     (lf_done_vec[i]),
            .acc_done    (acc_done_vec[i]),
            .active      (entry_active[i]),
            .entry_req   (entry_req[i]),
            .ds_want     (ds_want[i]),
            .ram_want    (ram_want[i]),
            .release_en  (entry_release[i])
        );
    end

    mshr_issue mshr_issue_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .ds_want          (ds_want),
        .ram_want         (ram_want),
        .entry_req        (entry_req),
        .ds_rdy           (ds_rdy),
        .ram_rdy          (ram_rdy),
        .linefill_done    (linefill_done),
        .linefill_done_id (linefill_done_id),
        .ram_done         (ram_done),
        .ram_done_id      (ram_done_id),
        .ds_grant         (ds_grant),
        .ram_grant        (ram_grant),
        .ds_req_vld       (ds_req_vld),
        .ds_req           (ds_req),
        .ram_req_vld      (ram_req_vld),
        .ram_req          (ram_req),
        .lf_done_vec      (lf_done_vec),
        .acc_done_vec     (acc_done_vec),
        .release_vec      (release_vec)
    );

endmodule

//--- verification/mshr_tb_ref.svh
`ifndef MSHR_TB_REF_SVH
`define MSHR_TB_REF_SVH

// ========================================
// random source
// ========================================
// one xorshift32 step
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

// ========================================
// expected requests
// ========================================
// line request of a miss
function automatic ds_req_t expect_ds(input cache_req_t r, input logic [ENTRY_ID_W-1:0] e);
    ds_req_t d;
    d.entry_id = e;
    d.txn_id   = r.txn_id;
    d.tag      = r.tag;
    d.index    = r.index;
    d.offset   = r.offset;
    return d;
endfunction

// data-RAM request
function automatic ram_req_t expect_ram(input cache_req_t r, input logic [ENTRY_ID_W-1:0] e);
    ram_req_t m;
    m.entry_id    = e;
    m.txn_id      = r.txn_id;
    m.opcode      = r.is_write ? OPC_WRITE : OPC_READ;
    m.way         = r.way;
    m.index       = r.index;
    m.offset      = r.offset;
    m.dest_ram_id = r.tag[TAG_W-1 -: DEST_RAM_W];   // top tag bits
    m.wdb_id      = r.is_write ? r.wdb_id : '0;
    return m;
endfunction

task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("CHECK FAILED %s: got %0h expected %0h at %0t", name, got, exp, $time);
    end
endtask

`endif

//--- verification/mshr_tb.sv
`timescale 1ns/1ps

module mshr_tb
    import mshr_pkg::*;
;

    localparam int          CLK_PERIOD      = 100;
    localparam int          NUM_TESTS       = 5;
    localparam int          REQS_PER_TEST   = 24;
    localparam int          CYCLES_PER_REQ  = 40;
    localparam int          WATCHDOG_CYCLES = NUM_TESTS * REQS_PER_TEST * CYCLES_PER_REQ;
    localparam int          TXN_NUM         = 1 << TXN_ID_W;
    localparam logic [31:0] SEED            = 32'hb6ea7d6d;

    logic clk;
    logic rst_n;
    logic req_vld;
    cache_req_t req;
    logic req_rdy;
    logic ds_req_vld;
    ds_req_t ds_req;
    logic ds_rdy;
    logic ram_req_vld;
    ram_req_t ram_req;
    logic ram_rdy;
    logic linefill_done;
    logic [ENTRY_ID_W-1:0] linefill_done_id;
    logic ram_done;
    logic [ENTRY_ID_W-1:0] ram_done_id;

    // scoreboard, indexed by txn_id
    cache_req_t exp_req [TXN_NUM];
    logic busy [TXN_NUM];
    logic lf_seen [TXN_NUM];
    int ds_cnt [TXN_NUM];
    int ram_cnt [TXN_NUM];
    int seq_no [TXN_NUM];
    logic [ENTRY_ID_W-1:0] txn_ent [TXN_NUM];
    logic [TXN_ID_W-1:0] ent_txn [MSHR_ENTRY_NUM];
    logic [MSHR_ENTRY_NUM-1:0] occ;              // entries holding a request
    int lf_wait [MSHR_ENTRY_NUM];                // cycles left before the pulse or -1 when idle
    int rd_wait [MSHR_ENTRY_NUM];
    int accepted_cnt;
    int completed_cnt;
    int seq_ctr;
    int errors;
    int checks;
    int errors_mark;
    int test_num;
    int ready_mode;                              // 0 low, 1 high, 2 random
    logic ds_hold;
    logic ram_hold;
    ds_req_t ds_prev;
    ram_req_t ram_prev;
    logic [31:0] stim_rng;
    logic [31:0] rdy_rng;
    logic [31:0] dly_rng;
    logic [TXN_ID_W-1:0] next_txn;

    `include "mshr_tb_ref.svh"

    mshr_top mshr_top_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .req_vld          (req_vld),
        .req              (req),
        .req_rdy          (req_rdy),
        .ds_req_vld       (ds_req_vld),
        .ds_req           (ds_req),
        .ds_rdy           (ds_rdy),
        .ram_req_vld      (ram_req_vld),
        .ram_req          (ram_req),
        .ram_rdy          (ram_rdy),
        .linefill_done    (linefill_done),
        .linefill_done_id (linefill_done_id),
        .ram_done         (ram_done),
        .ram_done_id      (ram_done_id)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Something failed");
        $finish;
    end

    task automatic flag_error(input string msg);
        errors++;
        $display("ERROR %s at %0t", msg, $time);
    endtask

    function automatic logic [ENTRY_ID_W-1:0] lowest_free(input logic [MSHR_ENTRY_NUM-1:0] used);
        logic [ENTRY_ID_W-1:0] pick;
        pick = '0;
        for (int i = MSHR_ENTRY_NUM - 1; i >= 0; i--) begin
            if (!used[i]) pick = ENTRY_ID_W'(i);
        end
        return pick;
    endfunction

    // ========================================
    // ready levels and completion responders
    // ========================================
    always @(posedge clk) begin : respond
        int lf_pick;
        int rd_pick;
        rdy_rng = xorshift32(rdy_rng);
        ds_rdy  <= (ready_mode == 1) || (ready_mode == 2 && (rdy_rng[0] | rdy_rng[1]));
        ram_rdy <= (ready_mode == 1) || (ready_mode == 2 && (rdy_rng[2] | rdy_rng[3]));
        linefill_done <= 1'b0;
        ram_done      <= 1'b0;
        lf_pick = -1;
        rd_pick = -1;
        for (int i = MSHR_ENTRY_NUM - 1; i >= 0; i--) begin
            if (lf_wait[i] > 0) lf_wait[i]--;
            if (rd_wait[i] > 0) rd_wait[i]--;
            if (lf_wait[i] == 0) lf_pick = i;
            if (rd_wait[i] == 0) rd_pick = i;
        end
        if (lf_pick >= 0) begin     // only one pulse per cycle so later picks wait
            linefill_done    <= 1'b1;
            linefill_done_id <= ENTRY_ID_W'(lf_pick);
            lf_wait[lf_pick] = -1;
        end
        if (rd_pick >= 0) begin
            ram_done    <= 1'b1;
            ram_done_id <= ENTRY_ID_W'(rd_pick);
            rd_wait[rd_pick] = -1;
        end
    end

    // ========================================
    // handshake monitor
    // ========================================
    // handshakes seen here land on the next rising edge
    task automatic check_order(input logic [TXN_ID_W-1:0] t, input string port);
        for (int u = 0; u < TXN_NUM; u++) begin
            if (busy[u] && seq_no[u] < seq_no[t] && exp_req[u].index == exp_req[t].index)
                flag_error($sformatf("%s request of txn %0d issued before older txn %0d finished",
                                     port, t, u));
        end
    endtask

    task automatic note_accept();
        logic [TXN_ID_W-1:0]   t;
        logic [ENTRY_ID_W-1:0] e;
        t = req.txn_id;
        e = lowest_free(occ);
        if (busy[t]) flag_error($sformatf("txn %0d accepted while still outstanding", t));
        busy[t]    = 1'b1;
        exp_req[t] = req;
        seq_no[t]  = seq_ctr;
        seq_ctr++;
        lf_seen[t] = 1'b0;
        ds_cnt[t]  = 0;
        ram_cnt[t] = 0;
        txn_ent[t] = e;
        ent_txn[e] = t;
        occ[e]     = 1'b1;
        accepted_cnt++;
    endtask

    task automatic note_ds();
        logic [TXN_ID_W-1:0] t;
        t = ds_req.txn_id;
        dly_rng = xorshift32(dly_rng);
        lf_wait[ds_req.entry_id] = 1 + int'(dly_rng[2:0]);
        if (!busy[t]) begin
            flag_error($sformatf("ds request for txn %0d which is not outstanding", t));
        end else begin
            if (exp_req[t].hit) flag_error($sformatf("ds request for hit txn %0d", t));
            if (ds_cnt[t] != 0) flag_error($sformatf("second ds request for txn %0d", t));
            check_order(t, "ds");
            check_eq("ds_req", 64'(ds_req), 64'(expect_ds(exp_req[t], txn_ent[t])));
            ds_cnt[t]++;
        end
    endtask

    task automatic note_ram();
        logic [TXN_ID_W-1:0] t;
        t = ram_req.txn_id;
        dly_rng = xorshift32(dly_rng);
        rd_wait[ram_req.entry_id] = 1 + int'(dly_rng[2:0]);
        if (!busy[t]) begin
            flag_error($sformatf("ram request for txn %0d which is not outstanding", t));
        end else begin
            if (!exp_req[t].hit && !lf_seen[t])
                flag_error($sformatf("ram request for miss txn %0d before its linefill", t));
            if (ram_cnt[t] != 0) flag_error($sformatf("second ram request for txn %0d", t));
            check_order(t, "ram");
            check_eq("ram_req", 64'(ram_req), 64'(expect_ram(exp_req[t], txn_ent[t])));
            ram_cnt[t]++;
        end
    endtask

    task automatic note_done(input logic [ENTRY_ID_W-1:0] e);
        logic [TXN_ID_W-1:0] t;
        t = ent_txn[e];
        if (!occ[e]) begin
            flag_error($sformatf("ram_done for idle entry %0d", e));
        end else begin
            check_eq("ram_req count", 64'(ram_cnt[t]), 64'd1);
            check_eq("ds_req count", 64'(ds_cnt[t]), exp_req[t].hit ? 64'd0 : 64'd1);
            busy[t] = 1'b0;
            occ[e]  = 1'b0;
            completed_cnt++;
        end
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            if (ds_hold) begin      // stalled last edge
                check_eq("ds_req_vld", 64'(ds_req_vld), 64'd1);
                check_eq("ds_req", 64'(ds_req), 64'(ds_prev));
            end
            if (ram_hold) begin
                check_eq("ram_req_vld", 64'(ram_req_vld), 64'd1);
                check_eq("ram_req", 64'(ram_req), 64'(ram_prev));
            end
            ds_hold  = ds_req_vld && !ds_rdy;
            ram_hold = ram_req_vld && !ram_rdy;
            ds_prev  = ds_req;
            ram_prev = ram_req;
            check_eq("req_rdy", 64'(req_rdy), 64'(!(&occ)));
            if (req_vld && req_rdy) note_accept();
            if (ds_req_vld && ds_rdy) note_ds();
            if (ram_req_vld && ram_rdy) note_ram();
            if (linefill_done) lf_seen[ent_txn[linefill_done_id]] = 1'b1;
            if (ram_done) note_done(ram_done_id);
        end
    end

    // ========================================
    // stimulus
    // ========================================
    task automatic send_req(input logic hit, input logic is_write, input logic [INDEX_W-1:0] index);
        cache_req_t r;
        stim_rng   = xorshift32(stim_rng);
        r.txn_id   = next_txn;
        r.is_write = is_write;
        r.hit      = hit;
        r.tag      = stim_rng[TAG_W-1:0];
        r.index    = index;
        r.offset   = stim_rng[16 +: OFFSET_W];
        r.way      = stim_rng[20 +: WAY_W];
        r.wdb_id   = stim_rng[24 +: WDB_ID_W];
        next_txn   = next_txn + 1'b1;
        @(posedge clk);
        req_vld <= 1'b1;
        req     <= r;
        @(negedge clk);
        while (!req_rdy) @(negedge clk);
        @(posedge clk);         // accepted on this edge
        req_vld <= 1'b0;
    endtask

    task automatic wait_idle();
        @(posedge clk);
        while (completed_cnt != accepted_cnt) @(posedge clk);
    endtask

    task automatic finish_test(input string name);
        @(posedge clk);
        test_num++;
        $display("test %0d %s: %0d errors", test_num, name, errors - errors_mark);
        errors_mark = errors;
    endtask

    initial begin
        rst_n = 1'b0;
        req_vld = 1'b0;
        req = '0;
        ds_rdy = 1'b0;
        ram_rdy = 1'b0;
        linefill_done = 1'b0;
        linefill_done_id = '0;
        ram_done = 1'b0;
        ram_done_id = '0;
        stim_rng = SEED;
        rdy_rng = xorshift32(SEED);
        dly_rng = xorshift32(rdy_rng);
        for (int i = 0; i < TXN_NUM; i++) busy[i] = 1'b0;
        for (int i = 0; i < MSHR_ENTRY_NUM; i++) begin
            lf_wait[i] = -1;
            rd_wait[i] = -1;
        end
        occ = '0;
        accepted_cnt = 0;
        completed_cnt = 0;
        seq_ctr = 0;
        errors = 0;
        checks = 0;
        errors_mark = 0;
        test_num = 0;
        ds_hold = 1'b0;
        ram_hold = 1'b0;
        next_txn = '0;
        ready_mode = 1;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        @(negedge clk);
        check_eq("req_rdy", 64'(req_rdy), 64'd1);
        check_eq("ds_req_vld", 64'(ds_req_vld), 64'd0);
        check_eq("ram_req_vld", 64'(ram_req_vld), 64'd0);
        finish_test("reset state");

        send_req(1'b1, 1'b0, 6'h05);
        send_req(1'b1, 1'b1, 6'h09);
        wait_idle();
        finish_test("hit read and hit write");

        send_req(1'b0, 1'b0, 6'h11);
        send_req(1'b0, 1'b1, 6'h12);
        wait_idle();
        finish_test("miss");

        @(negedge clk);
        ready_mode = 2;
        send_req(1'b0, 1'b0, 6'h20);    // same set three times
        send_req(1'b1, 1'b1, 6'h20);
        send_req(1'b0, 1'b1, 6'h21);
        send_req(1'b1, 1'b0, 6'h20);
        wait_idle();
        finish_test("same-index hazard");

        @(negedge clk);
        ready_mode = 0;                 // nothing issues or completes
        for (int i = 0; i < MSHR_ENTRY_NUM; i++) send_req(1'b1, 1'(i), INDEX_W'(48 + i));
        @(negedge clk);
        check_eq("req_rdy", 64'(req_rdy), 64'd0);
        repeat (6) @(posedge clk);
        @(negedge clk);
        ready_mode = 2;
        for (int n = 0; n < REQS_PER_TEST; n++) begin
            stim_rng = xorshift32(stim_rng);
            send_req(stim_rng[2], stim_rng[3], INDEX_W'(stim_rng[5:4]));
            repeat (int'(stim_rng[7:6])) @(posedge clk);
        end
        wait_idle();
        finish_test("fullness and random traffic");

        $display("%0d tests, %0d checks, %0d errors", test_num, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+verification
common/mshr_pkg.sv
hdl/mshr_alloc.sv
mshr_entry/mshr_entry.sv
hdl/mshr_issue.sv
hdl/mshr_top.sv
verification/mshr_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the MSHR testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=mshr_sim

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found"
    exit 1
fi

verilator --binary --timing --assert -f sim.f --top-module mshr_tb -Mdir "$OBJ" -o "$BIN"
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" "$LOG"; then
    echo "FAIL"
    exit 1
fi
if ! grep -q "Everything OK" "$LOG"; then
    echo "no result line in $LOG"
    exit 1
fi
echo "PASS"
exit 0
